//--- dbg_mam_pkg.sv
package dbg_mam_pkg;

   // -------------------------------------------------------------------
   // Debug network flit format
   // -------------------------------------------------------------------

   // Two type bits on top of 16 content bits
   typedef logic [17:0] flit_t;
   typedef logic [15:0] flit_content_t;

   localparam int FLIT_TYPE_MSB    = 17;
   localparam int FLIT_TYPE_LSB    = 16;
   localparam int FLIT_CONTENT_MSB = 15;

   // Header flit fields, counted within the content
   localparam int DEST_MSB       = 15;
   localparam int DEST_LSB       = 11;
   localparam int CLASS_MSB      = 10;
   localparam int CLASS_LSB      = 8;
   localparam int CLASS_BYTE_MSB = 7;
   localparam int CLASS_BYTE_LSB = 0;

   localparam int DEST_W = DEST_MSB - DEST_LSB + 1;

   typedef enum logic [1:0] {
      PAYLOAD = 2'b00,
      HEADER  = 2'b01,
      LAST    = 2'b10
   } flit_type_t;

   typedef enum logic [2:0] {
      CLASS_CONF = 3'b001,
      CLASS_MEM  = 3'b111
   } pkt_class_t;

   // Identity reported in configuration register 0
   localparam logic [7:0] MODULE_TYPE_MAM    = 8'h07;
   localparam logic [7:0] MODULE_VERSION_MAM = 8'h00;

   // -------------------------------------------------------------------
   // Memory side
   // -------------------------------------------------------------------

   typedef logic [31:0] mem_addr_t;
   typedef logic [31:0] mem_word_t;

   // Address in 63:32, data in 31:0
   typedef logic [63:0] wr_cmd_t;

   typedef enum logic [2:0] {
      IDLE_HDR,
      CONF_SEND,
      ADDR_MSB,
      ADDR_LSB,
      DATA_MSB,
      DATA_MSB_NEXT,
      DATA_LSB
   } noc_state_t;

   typedef enum logic [1:0] {
      WB_IDLE,
      WB_STROBE,
      WB_WAIT
   } wb_state_t;

endpackage

//--- dbg_conf_if.sv
`timescale 1ns/10ps

module dbg_conf_if
   import dbg_mam_pkg::*;
#(
   parameter logic [15:0] MEMORY_ID = 16'h0000
) (
   input  logic  clk,
   input  logic  rst,

   // Incoming flits, already qualified by the other ready terms
   input  flit_t in_flit_i,
   input  logic  in_valid_i,
   output logic  in_ready_o,

   // Response link, shared with the rest of the unit
   output flit_t out_flit_o,
   output logic  out_valid_o,
   input  logic  out_ready_i,

   output logic  conf_rts_o,
   input  logic  conf_cts_i
);

   typedef enum logic [2:0] {
      CF_IDLE,
      CF_REQ,
      CF_RTS,
      CF_HDR,
      CF_LAST
   } conf_state_t;

   conf_state_t       state_q;
   logic              in_accept;
   logic [DEST_W-1:0] rsp_dest_q;
   flit_content_t     rsp_data_q;
   flit_content_t     in_content;

   assign in_content = in_flit_i[FLIT_CONTENT_MSB:0];
   assign in_accept  = in_valid_i & in_ready_o;

   // Only the request phases take input
   assign in_ready_o  = (state_q == CF_IDLE) || (state_q == CF_REQ);
   assign conf_rts_o  = (state_q == CF_RTS) || (state_q == CF_HDR) || (state_q == CF_LAST);
   assign out_valid_o = (state_q == CF_HDR) || (state_q == CF_LAST);

   // -------------------------------------------------------------------
   // Request decode and response sequencing
   // -------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= CF_IDLE;
      end else begin
         case (state_q)
            CF_IDLE: begin
               if (in_accept && in_flit_i[FLIT_TYPE_MSB:FLIT_TYPE_LSB] == HEADER &&
                   in_content[CLASS_MSB:CLASS_LSB] == CLASS_CONF) begin
                  state_q <= CF_REQ;
               end
            end
            CF_REQ: begin
               // Register index arrives in the LAST flit
               if (in_accept && in_flit_i[FLIT_TYPE_MSB:FLIT_TYPE_LSB] == LAST) begin
                  state_q <= CF_RTS;
               end
            end
            CF_RTS: begin
               if (conf_cts_i) begin
                  state_q <= CF_HDR;
               end
            end
            CF_HDR: begin
               if (out_ready_i) begin
                  state_q <= CF_LAST;
               end
            end
            CF_LAST: begin
               if (out_ready_i) begin
                  state_q <= CF_IDLE;
               end
            end
            default: begin
               state_q <= CF_IDLE;
            end
         endcase
      end
   end

   // Requester address and register contents
   always_ff @(posedge clk) begin
      if (state_q == CF_IDLE && in_accept) begin
         rsp_dest_q <= in_content[CLASS_BYTE_LSB +: DEST_W];
      end
      if (state_q == CF_REQ && in_accept) begin
         case (in_content)
            16'd0:   rsp_data_q <= {MODULE_TYPE_MAM, MODULE_VERSION_MAM};
            16'd1:   rsp_data_q <= MEMORY_ID;
            default: rsp_data_q <= '0;
         endcase
      end
   end

   // Header back to the requester, then the register value
   always_comb begin
      if (state_q == CF_HDR) begin
         out_flit_o = {HEADER, rsp_dest_q, CLASS_CONF, 8'h00};
      end else begin
         out_flit_o = {LAST, rsp_data_q};
      end
   end

   // The link is ours only while the top level grants it
   a_valid_needs_cts: assert property (@(posedge clk) disable iff (rst)
      out_valid_o |-> conf_cts_i);

endmodule

//--- mem_write_fifo.sv
`timescale 1ns/10ps

module mem_write_fifo
   import dbg_mam_pkg::*;
#(
   parameter int DEPTH = 4
) (
   input  logic    clk,
   input  logic    rst,

   input  logic    push_i,
   input  wr_cmd_t cmd_i,
   output logic    full_o,

   input  logic    pop_i,
   output wr_cmd_t cmd_o,
   output logic    empty_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   wr_cmd_t           mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr_q;
   logic [PTR_W-1:0]  rd_ptr_q;
   logic [CNT_W-1:0]  count_q;
   logic              do_push;
   logic              do_pop;

   assign full_o  = (count_q == CNT_W'(DEPTH));
   assign empty_o = (count_q == '0);
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   // Head entry is visible one cycle after its push
   assign cmd_o = mem[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr_q] <= cmd_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   a_no_push_full: assert property (@(posedge clk) disable iff (rst)
      push_i |-> !full_o);

endmodule

//--- mam_wb_master.sv
`timescale 1ns/10ps

module mam_wb_master
   import dbg_mam_pkg::*;
(
   input  logic       clk,
   input  logic       rst,

   // Write command FIFO
   input  wr_cmd_t    cmd_i,
   input  logic       empty_i,
   output logic       pop_o,

   // Wishbone master, classic single cycle
   output mem_addr_t  wb_adr_o,
   output mem_word_t  wb_dat_o,
   output logic [3:0] wb_sel_o,
   output logic       wb_we_o,
   output logic       wb_stb_o,
   output logic       wb_cyc_o,
   input  logic       wb_ack_i
);

   wb_state_t state_q;

   // Take a command only from idle
   assign pop_o = (state_q == WB_IDLE) && !empty_i;

   // Address and data registers
   always_ff @(posedge clk) begin
      if (pop_o) begin
         wb_adr_o <= cmd_i[63:32];
         wb_dat_o <= cmd_i[31:0];
      end
   end

   // -------------------------------------------------------------------
   // Bus cycle control
   // -------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q  <= WB_IDLE;
         wb_stb_o <= 1'b0;
         wb_cyc_o <= 1'b0;
         wb_we_o  <= 1'b0;
         wb_sel_o <= 4'b0000;
      end else begin
         case (state_q)
            WB_IDLE: begin
               if (pop_o) begin
                  state_q  <= WB_STROBE;
                  wb_stb_o <= 1'b1;
                  wb_cyc_o <= 1'b1;
                  wb_we_o  <= 1'b1;
                  wb_sel_o <= 4'b1111;
               end
            end
            WB_STROBE, WB_WAIT: begin
               if (wb_ack_i) begin
                  // Back to idle for at least one cycle
                  state_q  <= WB_IDLE;
                  wb_stb_o <= 1'b0;
                  wb_cyc_o <= 1'b0;
                  wb_we_o  <= 1'b0;
                  wb_sel_o <= 4'b0000;
               end else begin
                  state_q <= WB_WAIT;
               end
            end
            default: begin
               state_q <= WB_IDLE;
            end
         endcase
      end
   end

   a_stb_ends_on_ack: assert property (@(posedge clk) disable iff (rst)
      ($fell(wb_stb_o) || $fell(wb_cyc_o)) |-> $past(wb_ack_i));

endmodule

//--- mam.sv
`timescale 1ns/10ps

module mam
   import dbg_mam_pkg::*;
#(
   parameter logic [15:0] MEMORY_ID  = 16'h0000,
   parameter int          FIFO_DEPTH = 4
) (
   input  logic       clk,
   input  logic       rst,

   // Debug network input
   input  flit_t      in_flit_i,
   input  logic       in_valid_i,
   output logic       in_ready_o,

   // Debug network output
   output flit_t      out_flit_o,
   output logic       out_valid_o,
   input  logic       out_ready_i,

   // Wishbone master
   output mem_addr_t  wb_adr_o,
   output mem_word_t  wb_dat_o,
   output logic [3:0] wb_sel_o,
   output logic       wb_we_o,
   output logic       wb_stb_o,
   output logic       wb_cyc_o,
   input  logic       wb_ack_i
);

   noc_state_t    state_q;
   noc_state_t    state_d;
   flit_content_t in_content;
   logic          in_accept;
   logic          is_mem_wr_hdr;
   logic          lsb_accept;

   // Command under assembly
   mem_addr_t     wr_addr_q;
   mem_word_t     wr_data_q;
   logic          fifo_push_q;
   logic          fifo_full;
   logic          fifo_pop;
   logic          fifo_empty;
   wr_cmd_t       fifo_cmd;

   // Configuration block link
   logic          conf_in_valid;
   logic          conf_in_ready;
   logic          conf_rts;
   logic          conf_cts;
   logic          conf_out_ready;
   logic          conf_out_valid;
   flit_t         conf_out_flit;

   assign in_content = in_flit_i[FLIT_CONTENT_MSB:0];
   assign in_ready_o = (state_q != CONF_SEND) & conf_in_ready & ~fifo_full;
   assign in_accept  = in_valid_i & in_ready_o;
   assign lsb_accept = in_accept && (state_q == DATA_LSB);

   // Memory write header: class MEM with a zero class byte
   assign is_mem_wr_hdr = (in_flit_i[FLIT_TYPE_MSB:FLIT_TYPE_LSB] == HEADER) &&
                          (in_content[CLASS_MSB:CLASS_LSB] == CLASS_MEM) &&
                          (in_content[CLASS_BYTE_MSB:CLASS_BYTE_LSB] == 8'h00);

   // -------------------------------------------------------------------
   // Outgoing link sharing
   // -------------------------------------------------------------------

   assign conf_in_valid  = in_valid_i & (state_q != CONF_SEND) & ~fifo_full;
   assign conf_out_ready = out_ready_i & conf_cts;
   assign out_flit_o     = conf_out_flit;
   assign out_valid_o    = conf_out_valid;

   // -------------------------------------------------------------------
   // Network FSM
   // -------------------------------------------------------------------

   always_comb begin
      state_d  = state_q;
      conf_cts = 1'b0;
      case (state_q)
         IDLE_HDR: begin
            // A waiting input flit would be lost under a grant
            if (!in_valid_i && conf_rts) begin
               state_d = CONF_SEND;
            end else if (in_accept && is_mem_wr_hdr) begin
               state_d = ADDR_MSB;
            end
         end
         CONF_SEND: begin
            if (conf_rts || conf_out_valid) begin
               conf_cts = 1'b1;
            end else begin
               state_d = IDLE_HDR;
            end
         end
         ADDR_MSB: begin
            if (in_accept) state_d = ADDR_LSB;
         end
         ADDR_LSB: begin
            if (in_accept) state_d = DATA_MSB;
         end
         DATA_MSB, DATA_MSB_NEXT: begin
            if (in_accept) state_d = DATA_LSB;
         end
         DATA_LSB: begin
            if (in_accept) begin
               if (in_flit_i[FLIT_TYPE_MSB:FLIT_TYPE_LSB] == LAST) begin
                  state_d = IDLE_HDR;
               end else begin
                  state_d = DATA_MSB_NEXT;
               end
            end
         end
         default: begin
            state_d = IDLE_HDR;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q     <= IDLE_HDR;
         fifo_push_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         fifo_push_q <= lsb_accept;
      end
   end

   // Address and data halves
   always_ff @(posedge clk) begin
      if (in_accept) begin
         case (state_q)
            ADDR_MSB:      wr_addr_q[31:16] <= in_content;
            ADDR_LSB:      wr_addr_q[15:0]  <= in_content;
            DATA_MSB:      wr_data_q[31:16] <= in_content;
            DATA_MSB_NEXT: begin
               wr_data_q[31:16] <= in_content;
               wr_addr_q        <= wr_addr_q + 32'd4;
            end
            DATA_LSB:      wr_data_q[15:0]  <= in_content;
            default:       ;
         endcase
      end
   end

   // -------------------------------------------------------------------
   // Sub-blocks
   // -------------------------------------------------------------------

   dbg_conf_if #(
      .MEMORY_ID (MEMORY_ID)
   ) u_conf_if (
      .clk         (clk),
      .rst         (rst),
      .in_flit_i   (in_flit_i),
      .in_valid_i  (conf_in_valid),
      .in_ready_o  (conf_in_ready),
      .out_flit_o  (conf_out_flit),
      .out_valid_o (conf_out_valid),
      .out_ready_i (conf_out_ready),
      .conf_rts_o  (conf_rts),
      .conf_cts_i  (conf_cts)
   );

   mem_write_fifo #(
      .DEPTH (FIFO_DEPTH)
   ) u_mem_write_fifo (
      .clk     (clk),
      .rst     (rst),
      .push_i  (fifo_push_q),
      .cmd_i   ({wr_addr_q, wr_data_q}),
      .full_o  (fifo_full),
      .pop_i   (fifo_pop),
      .cmd_o   (fifo_cmd),
      .empty_o (fifo_empty)
   );

   mam_wb_master u_wb_master (
      .clk      (clk),
      .rst      (rst),
      .cmd_i    (fifo_cmd),
      .empty_i  (fifo_empty),
      .pop_o    (fifo_pop),
      .wb_adr_o (wb_adr_o),
      .wb_dat_o (wb_dat_o),
      .wb_sel_o (wb_sel_o),
      .wb_we_o  (wb_we_o),
      .wb_stb_o (wb_stb_o),
      .wb_cyc_o (wb_cyc_o),
      .wb_ack_i (wb_ack_i)
   );

   // The push one cycle after a lower data half always finds room
   a_push_has_room: assert property (@(posedge clk) disable iff (rst)
      lsb_accept |=> !fifo_full);

   // Grant starts only after a cycle without a waiting input flit
   a_grant_no_input: assert property (@(posedge clk) disable iff (rst)
      $rose(conf_cts) |-> $past(!in_valid_i));

endmodule

//--- tb_mam_checks.svh
// -------------------------------------------------------------------
// Compare tasks
// -------------------------------------------------------------------

task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
   if (act !== exp) begin
      $display("[FAIL] %s: address expected %h, actual %h", name, exp, act);
      abort_run();
   end
endtask

task automatic check_data(input string name, input mem_word_t exp, input mem_word_t act);
   if (act !== exp) begin
      $display("[FAIL] %s: data expected %h, actual %h", name, exp, act);
      abort_run();
   end
endtask

task automatic check_flit(input string name, input flit_t exp, input flit_t act);
   if (act !== exp) begin
      $display("[FAIL] %s: flit expected %h, actual %h", name, exp, act);
      abort_run();
   end
endtask

task automatic check_sel(input string name, input logic [3:0] exp, input logic [3:0] act);
   if (act !== exp) begin
      $display("[FAIL] %s: sel expected %b, actual %b", name, exp, act);
      abort_run();
   end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      abort_run();
   end
endtask

// -------------------------------------------------------------------
// Packet drivers, called on a falling edge
// -------------------------------------------------------------------

// Holds the flit until the edge that accepts it
task automatic send_flit(input flit_t f);
   in_flit  = f;
   in_valid = 1'b1;
   while (!in_ready) @(negedge clk);
   @(negedge clk);
endtask

task automatic send_write(input int idx);
   int         w;
   flit_type_t lsb_type;
   send_flit({HEADER, 5'd1, CLASS_MEM, 8'h00});
   send_flit({PAYLOAD, test_addr[idx][31:16]});
   send_flit({PAYLOAD, test_addr[idx][15:0]});
   for (w = 0; w < test_words[idx]; w++) begin
      if (w == test_words[idx] - 1) begin
         lsb_type = LAST;
      end else begin
         lsb_type = PAYLOAD;
      end
      send_flit({PAYLOAD, test_data[idx][w][31:16]});
      send_flit({lsb_type, test_data[idx][w][15:0]});
   end
   in_valid = 1'b0;
endtask

// Requester address sits in the low bits of the class byte
task automatic send_conf(input logic [4:0] req, input logic [15:0] reg_idx);
   send_flit({HEADER, 5'd1, CLASS_CONF, 3'b000, req});
   send_flit({LAST, reg_idx});
   in_valid = 1'b0;
endtask

//--- tb_mam.sv
`timescale 1ns/10ps

module tb_mam
   import dbg_mam_pkg::*;
();

   localparam int          CLK_PERIOD     = 40;
   localparam int          RESET_CYCLES   = 16;
   localparam int          NUM_TESTS      = 8;
   localparam int          TIMEOUT_CYCLES = NUM_TESTS * 60 + RESET_CYCLES;
   localparam logic [15:0] MEM_ID         = 16'h5a3c;

   logic        clk;
   logic        rst;
   flit_t       in_flit;
   logic        in_valid;
   logic        in_ready;
   flit_t       out_flit;
   logic        out_valid;
   logic        out_ready;
   mem_addr_t   wb_adr;
   mem_word_t   wb_dat;
   logic [3:0]  wb_sel;
   logic        wb_we;
   logic        wb_stb;
   logic        wb_cyc;
   logic        wb_ack;

   // Stimulus table
   string       test_name  [NUM_TESTS];
   bit          test_conf  [NUM_TESTS];
   bit          test_slow  [NUM_TESTS];
   mem_addr_t   test_addr  [NUM_TESTS];
   int          test_words [NUM_TESTS];
   mem_word_t   test_data  [NUM_TESTS][4];
   logic [4:0]  test_req   [NUM_TESTS];
   logic [15:0] test_reg   [NUM_TESTS];
   logic [15:0] test_exp   [NUM_TESTS];

   // Observed traffic and random draws
   mem_addr_t   wr_adr_q[$];
   mem_word_t   wr_dat_q[$];
   flit_t       rsp_q[$];
   int unsigned ack_delay_tab [64];
   bit          ready_tab [256];
   string       cur_name;
   bit          slow_ack;

   `include "tb_mam_checks.svh"

   // Shallow FIFO so that a slow ack fills it
   mam #(
      .MEMORY_ID  (MEM_ID),
      .FIFO_DEPTH (2)
   ) DUT (
      .clk         (clk),
      .rst         (rst),
      .in_flit_i   (in_flit),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .out_flit_o  (out_flit),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready),
      .wb_adr_o    (wb_adr),
      .wb_dat_o    (wb_dat),
      .wb_sel_o    (wb_sel),
      .wb_we_o     (wb_we),
      .wb_stb_o    (wb_stb),
      .wb_cyc_o    (wb_cyc),
      .wb_ack_i    (wb_ack)
   );

   task automatic abort_run();
      $display("Errors found");
      $fatal(1, "Run stopped");
   endtask

   task automatic add_write(input int idx, input string name, input mem_addr_t addr,
                            input int n, input mem_word_t w0, input mem_word_t w1,
                            input mem_word_t w2, input mem_word_t w3, input bit slow);
      test_name[idx]    = name;
      test_conf[idx]    = 1'b0;
      test_slow[idx]    = slow;
      test_addr[idx]    = addr;
      test_words[idx]   = n;
      test_data[idx][0] = w0;
      test_data[idx][1] = w1;
      test_data[idx][2] = w2;
      test_data[idx][3] = w3;
   endtask

   task automatic add_conf(input int idx, input string name, input logic [4:0] req,
                           input logic [15:0] reg_idx, input logic [15:0] exp);
      test_name[idx] = name;
      test_conf[idx] = 1'b1;
      test_slow[idx] = 1'b0;
      test_req[idx]  = req;
      test_reg[idx]  = reg_idx;
      test_exp[idx]  = exp;
   endtask

   initial begin : clock_gen
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // -------------------------------------------------------------------
   // Wishbone slave model, records each write at its ack
   // -------------------------------------------------------------------

   initial begin : wishbone_slave
      int unsigned wait_left;
      int          delay_idx;
      bit          pending;
      wb_ack    = 1'b0;
      wait_left = 0;
      delay_idx = 0;
      pending   = 1'b0;
      forever begin
         @(negedge clk);
         if (wb_ack) begin
            wb_ack = 1'b0;
         end else if (wb_stb && wb_cyc) begin
            if (!pending) begin
               wait_left = slow_ack ? 3 : ack_delay_tab[delay_idx % 64];
               delay_idx++;
               pending   = 1'b1;
            end
            if (wait_left == 0) begin
               check_flag({cur_name, " we"}, 1'b1, wb_we);
               check_sel({cur_name, " sel"}, 4'b1111, wb_sel);
               wr_adr_q.push_back(wb_adr);
               wr_dat_q.push_back(wb_dat);
               wb_ack  = 1'b1;
               pending = 1'b0;
            end else begin
               wait_left--;
            end
         end
      end
   end

   // Random gaps in out_ready, flits recorded ahead of the accepting edge
   initial begin : response_collector
      int gap_idx;
      gap_idx   = 0;
      out_ready = 1'b0;
      forever begin
         @(negedge clk);
         out_ready = ready_tab[gap_idx % 256];
         gap_idx++;
         if (out_valid && out_ready) begin
            rsp_q.push_back(out_flit);
         end
      end
   end

   initial begin : watchdog
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
   end

   initial begin : main_sequence
      int i;
      int w;
      void'($urandom(32'h9acc7392));
      for (i = 0; i < 64; i++) ack_delay_tab[i] = $urandom_range(3, 0);
      for (i = 0; i < 256; i++) ready_tab[i] = ($urandom_range(3, 0) != 0);

      add_write(0, "write_one", 32'h0000_1000, 1, 32'hdead_beef, 0, 0, 0, 1'b0);
      add_write(1, "write_multi", 32'h2000_fff8, 3, 32'h1111_0001, 32'h2222_0002,
                32'h3333_0003, 0, 1'b0);
      add_conf(2, "conf_type_version", 5'd9, 16'd0, 16'h0700);
      add_conf(3, "conf_memory_id", 5'd17, 16'd1, MEM_ID);
      add_conf(4, "conf_bad_index", 5'd2, 16'd5, 16'h0000);
      add_write(5, "write_slow_ack", 32'h8000_0000, 4, 32'ha5a5_0f0f, 32'h0123_4567,
                32'h89ab_cdef, 32'hffff_0000, 1'b1);
      add_conf(6, "conf_with_gaps", 5'd31, 16'd0, 16'h0700);
      add_write(7, "write_after_conf", 32'h0000_0040, 2, 32'hcafe_f00d, 32'h0bad_c0de, 0, 0,
                1'b0);

      rst      = 1'b1;
      in_flit  = '0;
      in_valid = 1'b0;
      slow_ack = 1'b0;
      cur_name = "reset";
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;

      check_flag("reset in_ready", 1'b1, in_ready);
      check_flag("reset out_valid", 1'b0, out_valid);
      check_flag("reset wb_stb", 1'b0, wb_stb);
      check_flag("reset wb_cyc", 1'b0, wb_cyc);
      check_flag("reset wb_we", 1'b0, wb_we);

      for (i = 0; i < NUM_TESTS; i++) begin
         cur_name = test_name[i];
         slow_ack = test_slow[i];
         if (test_conf[i]) begin
            send_conf(test_req[i], test_reg[i]);
            while (rsp_q.size() < 2) @(negedge clk);
            check_flit({cur_name, " header"}, {HEADER, test_req[i], CLASS_CONF, 8'h00},
                       rsp_q.pop_front());
            check_flit({cur_name, " value"}, {LAST, test_exp[i]}, rsp_q.pop_front());
         end else begin
            send_write(i);
            while (wr_adr_q.size() < test_words[i]) @(negedge clk);
            for (w = 0; w < test_words[i]; w++) begin
               check_addr(cur_name, test_addr[i] + 32'(4 * w), wr_adr_q.pop_front());
               check_data(cur_name, test_data[i][w], wr_dat_q.pop_front());
            end
         end
      end

      // Quiet period to catch stray writes or flits
      repeat (8) @(negedge clk);
      if (wr_adr_q.size() != 0 || rsp_q.size() != 0) begin
         $display("Unexpected extra Wishbone writes or response flits after the last test");
         abort_run();
      end else begin
         $display("No errors");
         $finish;
      end
   end

endmodule

//--- sources.f
+incdir+.
dbg_mam_pkg.sv
dbg_conf_if.sv
mem_write_fifo.sv
mam_wb_master.sv
mam.sv
tb_mam.sv
